//--- compile.f
common/hdmi_tx_pkg.sv
logic/init_rom.sv
i2c_master/i2c_master.sv
logic/init_sequencer.sv
logic/hdmi_tx_init.sv
verif/adv7513_model.sv
verif/tb_checker.sv
verif/tb_hdmi_tx_init.sv

//--- verif/tb_hdmi_tx_init.sv
`timescale 1ns/1ns

module tb_hdmi_tx_init
    import hdmi_tx_pkg::*;
();

    localparam int CLK_DIV = 4;
    localparam bit ASPECT_16_9 = 1'b0;
    localparam int READY_LIMIT = 60000;

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    tri1        sda;
    tri1        scl;
    logic       ready;
    logic [7:0] pll_errors;
    i2c_req_t   txn;
    logic [7:0] addr_byte;
    logic [7:0] rd_addr_byte;
    logic       value_nacked;
    logic       master_nacked;
    int         txn_count;
    int         nack_write;
    int         nack_pick;
    int         unlocked_reads;
    int         errors;
    int         nacks_seen;
    int         locks_seen;
    int         tb_errors;
    bit         timed_out;
    logic [31:0] lfsr;

    hdmi_tx_init #(.CLK_DIV(CLK_DIV), .ASPECT_16_9(ASPECT_16_9)) uut (
        .clk(clk), .reset(reset), .hdmi_int(hdmi_int), .sda(sda), .scl(scl),
        .ready(ready), .pll_errors(pll_errors)
    );

    adv7513_model u_model (
        .sda(sda), .scl(scl), .nack_write(nack_write), .unlocked_reads(unlocked_reads),
        .txn(txn), .addr_byte(addr_byte), .rd_addr_byte(rd_addr_byte),
        .value_nacked(value_nacked), .master_nacked(master_nacked), .txn_count(txn_count)
    );

    tb_checker #(.ASPECT_16_9(ASPECT_16_9)) u_checker (
        .clk(clk), .reset(reset), .hdmi_int(hdmi_int), .ready(ready),
        .pll_errors(pll_errors), .txn(txn), .addr_byte(addr_byte),
        .rd_addr_byte(rd_addr_byte), .value_nacked(value_nacked),
        .master_nacked(master_nacked), .txn_count(txn_count), .errors(errors),
        .nacks_seen(nacks_seen), .locks_seen(locks_seen)
    );

    always #50 clk = ~clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic wait_ready(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (ready !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (ready !== level) begin
            $display("%0t ns: timeout, ready did not become %0d %s", $time, level, what);
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b0;
        hdmi_int  = 1'b1;
        tb_errors = 0;
        timed_out = 1'b0;
        lfsr      = 32'h9674;
        draw_bits(5, nack_pick);
        nack_write = nack_pick % INIT_LEN;
        draw_bits(2, unlocked_reads);
        $display("NACK on write %0d, %0d unlocked PLL reads", nack_write, unlocked_reads);
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        wait_ready(1'b1, READY_LIMIT, "after reset");
        if (!timed_out) begin
            @(posedge clk);
            hdmi_int <= 1'b0;
            wait_ready(1'b0, 4, "after hdmi_int fell");
            @(posedge clk);
            hdmi_int <= 1'b1;
        end
        if (!timed_out) wait_ready(1'b1, READY_LIMIT, "after the interrupt rerun");
        if (!timed_out) begin
            if (pll_errors !== 8'(unlocked_reads)) begin
                $display("[ERROR] %0t ns pll_errors: got %0d, expected %0d", $time,
                         pll_errors, unlocked_reads);
                tb_errors++;
            end
            if (nacks_seen != 1) begin
                $display("the injected NACK was seen %0d times instead of once", nacks_seen);
                tb_errors++;
            end
            if (locks_seen != 2) begin
                $display("PLL lock was reported %0d times instead of twice", locks_seen);
                tb_errors++;
            end
        end
        $display("checker errors %0d, testbench errors %0d, transactions %0d",
                 errors, tb_errors, txn_count);
        if (errors == 0 && tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ns

module tb_checker
    import hdmi_tx_pkg::*;
#(
    parameter bit ASPECT_16_9 = 1'b0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    input  logic       ready,
    input  logic [7:0] pll_errors,
    input  i2c_req_t   txn,
    input  logic [7:0] addr_byte,
    input  logic [7:0] rd_addr_byte,
    input  logic       value_nacked,
    input  logic       master_nacked,
    input  int         txn_count,
    output int         errors,
    output int         nacks_seen,
    output int         locks_seen
);

    // cycles from the logged lock read to ready, a stop symbol plus margin
    localparam int LOCK_LIMIT = 32;

    localparam logic [0:INIT_LEN-1][15:0] TABLE = {
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4,
        16'hA3A4, 16'hE0D0, 16'hF900, 16'h1500, 16'h1630, 16'h1700,
        16'h1846, 16'hAF06, 16'hBA60, 16'h0A00, 16'h0100, 16'h0218,
        16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h94C0, 16'h96C0
    };

    int seen = 0;
    int exp_idx = 0;
    int unlocked_seen = 0;
    int lock_wait = 0;
    int int_wait = 0;
    bit configured = 1'b0;
    bit ready_seen = 1'b0;
    bit prev_ready = 1'b0;

    initial begin
        errors     = 0;
        nacks_seen = 0;
        locks_seen = 0;
    end

    function automatic init_entry_t expected_entry(input int idx, input bit aspect);
        init_entry_t e;
        e = TABLE[idx];
        // 16:9 aspect flag
        if (e.reg_addr == 8'h17 && aspect) begin
            e.value[1] = 1'b1;
        end
        return e;
    endfunction

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic rule_error(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic check_txn();
        init_entry_t exp;
        if (pll_errors != 8'(unlocked_seen)) value_error("pll_errors", pll_errors, unlocked_seen);
        if (addr_byte != 8'h72) value_error("address byte", addr_byte, 8'h72);
        if (configured) begin
            rule_error("bus transaction while the transmitter is configured");
        end else if (exp_idx < INIT_LEN) begin
            exp = expected_entry(exp_idx, ASPECT_16_9);
            if (txn.is_read) rule_error("read where a table write was expected");
            if ({txn.reg_addr, txn.value} != exp) value_error("write reg/value",
                {txn.reg_addr, txn.value}, exp);
            // a NACKed write must come back as the very next transaction
            if (value_nacked) nacks_seen++;
            else exp_idx++;
        end else begin
            if (!txn.is_read) rule_error("write where the PLL status read was expected");
            if (txn.reg_addr != REG_PLL_STATUS) value_error("read reg", txn.reg_addr,
                REG_PLL_STATUS);
            if (rd_addr_byte != 8'h73) value_error("read address byte", rd_addr_byte, 8'h73);
            if (!master_nacked) rule_error("master acknowledged the PLL status byte");
            if (txn.value[PLL_LOCK_BIT]) begin
                locks_seen++;
                configured = 1'b1;
                lock_wait  = 0;
            end else begin
                unlocked_seen++;
                exp_idx = 0;
            end
        end
    endtask

    task automatic check_ready();
        if (configured && ready) begin
            ready_seen = 1'b1;
            if (!hdmi_int) begin
                int_wait++;
                if (int_wait == 4) rule_error("ready still high 3 cycles after hdmi_int fell");
            end
        end else if (configured && ready_seen) begin
            if (int_wait == 0) rule_error("ready fell without an interrupt");
            configured = 1'b0;
            ready_seen = 1'b0;
            int_wait   = 0;
            exp_idx    = 0;
        end else if (configured) begin
            lock_wait++;
            if (lock_wait == LOCK_LIMIT) rule_error("ready did not rise after PLL lock");
        end else if (ready && !prev_ready) begin
            value_error("ready", ready, 16'h0);
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if (txn_count != seen) begin
                seen = txn_count;
                check_txn();
            end
            check_ready();
            prev_ready = ready;
        end
    end

endmodule

//--- verif/adv7513_model.sv
`timescale 1ns/1ns

module adv7513_model
    import hdmi_tx_pkg::*;
(
    inout  wire        sda,
    input  wire        scl,
    input  int         nack_write,
    input  int         unlocked_reads,
    output i2c_req_t   txn,
    output logic [7:0] addr_byte,
    output logic [7:0] rd_addr_byte,
    output logic       value_nacked,
    output logic       master_nacked,
    output int         txn_count
);

    logic [7:0] regs [256];
    logic       active = 1'b0;
    logic       reading = 1'b0;
    logic       drive_low = 1'b0;
    logic       nack_done = 1'b0;
    int         writes = 0;
    int         pll_reads = 0;
    int         bitn;
    int         byte_no;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [7:0] cur_addr;
    logic [7:0] cur_rd_addr;
    logic [7:0] cur_reg;
    logic [7:0] cur_value;
    logic       cur_nacked;
    logic       cur_mnack;
    logic       got_read;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        txn           = '0;
        addr_byte     = 8'h00;
        rd_addr_byte  = 8'h00;
        value_nacked  = 1'b0;
        master_nacked = 1'b0;
        txn_count     = 0;
    end

    // decide what a completed byte is and whether to ack it
    task automatic take_byte();
        drive_low = 1'b1;
        if (byte_no == 0 && shift[0]) begin
            cur_rd_addr = shift;
            got_read    = 1'b1;
            reading     = 1'b1;
            drive_low   = (shift[7:1] == CHIP_ADDR);
            // status answers unlocked (every bit but the lock flag) a set number of times
            if (cur_reg == REG_PLL_STATUS) begin
                tx_byte   = (pll_reads < unlocked_reads) ? 8'hEF : 8'h10;
                pll_reads = pll_reads + 1;
            end else begin
                tx_byte = regs[cur_reg];
            end
            cur_value = tx_byte;
        end else if (byte_no == 0) begin
            cur_addr  = shift;
            drive_low = (shift[7:1] == CHIP_ADDR);
        end else if (byte_no == 1) begin
            cur_reg = shift;
        end else if (byte_no == 2) begin
            cur_value = shift;
            if (writes == nack_write && !nack_done) begin
                drive_low  = 1'b0;
                nack_done  = 1'b1;
                cur_nacked = 1'b1;
            end else begin
                regs[cur_reg] = shift;
            end
            writes = writes + 1;
        end
    endtask

    // START or repeated START, a real fall to 0 with scl high
    always @(negedge sda) begin
        if (sda === 1'b0 && scl === 1'b1) begin
            if (active !== 1'b1) begin
                got_read    = 1'b0;
                cur_rd_addr = 8'h00;
                cur_reg     = 8'h00;
                cur_value   = 8'h00;
                cur_nacked  = 1'b0;
                cur_mnack   = 1'b0;
            end
            active    = 1'b1;
            reading   = 1'b0;
            drive_low = 1'b0;
            bitn      = 0;
            byte_no   = 0;
        end
    end

    // STOP closes the transaction and publishes it
    always @(posedge sda) begin
        if (scl === 1'b1 && active === 1'b1) begin
            active = 1'b0;
            txn = '{chip_addr: cur_addr[7:1], reg_addr: cur_reg, value: cur_value,
                    is_read: got_read};
            addr_byte     = cur_addr;
            rd_addr_byte  = cur_rd_addr;
            value_nacked  = cur_nacked;
            master_nacked = cur_mnack;
            txn_count     = txn_count + 1;
        end
    end

    always @(posedge scl) begin
        if (active === 1'b1) begin
            if (bitn < 8) begin
                shift = {shift[6:0], sda};
            end else if (reading) begin
                cur_mnack = sda;
            end
            bitn = bitn + 1;
        end
    end

    // sda only changes while scl is low
    always @(negedge scl) begin
        if (active === 1'b1) begin
            if (bitn == 8 && reading) begin
                drive_low = 1'b0;
            end else if (bitn == 8) begin
                take_byte();
            end else if (bitn == 9) begin
                drive_low = reading && byte_no == 0 && !tx_byte[7];
                byte_no   = byte_no + 1;
                bitn      = 0;
            end else if (bitn > 0 && reading) begin
                drive_low = !tx_byte[7 - bitn];
            end
        end
    end

endmodule

//--- logic/hdmi_tx_init.sv
`timescale 1ns/1ns

module hdmi_tx_init
    import hdmi_tx_pkg::*;
#(
    parameter int CLK_DIV = 4,
    parameter bit ASPECT_16_9 = 1'b0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    inout  wire        sda,
    inout  wire        scl,
    output logic       ready,
    output logic [7:0] pll_errors
);

    init_entry_t entry;
    i2c_req_t    req;
    i2c_rsp_t    rsp;
    logic [4:0]  index;
    logic        start;
    logic        busy;
    logic        done;

    init_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .hdmi_int   (hdmi_int),
        .entry      (entry),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .index      (index),
        .req        (req),
        .start      (start),
        .ready      (ready),
        .pll_errors (pll_errors)
    );

    init_rom #(
        .ASPECT_16_9 (ASPECT_16_9)
    ) u_rom (
        .index (index),
        .entry (entry)
    );

    i2c_master #(
        .CLK_DIV (CLK_DIV)
    ) u_i2c (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .start (start),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp),
        .sda   (sda),
        .scl   (scl)
    );

endmodule

//--- logic/init_sequencer.sv
`timescale 1ns/1ns

module init_sequencer
    import hdmi_tx_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        hdmi_int,
    input  init_entry_t entry,
    input  logic        busy,
    input  logic        done,
    input  i2c_rsp_t    rsp,
    output logic [4:0]  index,
    output i2c_req_t    req,
    output logic        start,
    output logic        ready,
    output logic [7:0]  pll_errors
);

    localparam i2c_req_t PLL_READ = '{
        chip_addr: CHIP_ADDR,
        reg_addr:  REG_PLL_STATUS,
        value:     8'h00,
        is_read:   1'b1
    };

    seq_state_e state;
    logic       int_meta;
    logic       int_sync;

    function automatic i2c_req_t write_req(init_entry_t e);
        write_req = '{
            chip_addr: CHIP_ADDR,
            reg_addr:  e.reg_addr,
            value:     e.value,
            is_read:   1'b0
        };
    endfunction

    // interrupt is active low and asynchronous to clk
    always_ff @(posedge clk) begin
        if (!reset) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= hdmi_int;
            int_sync <= int_meta;
        end
    end

    // index always points at the entry after the one on the bus,
    // so req still holds the entry to retry after a NACK
    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= s_issue;
            index      <= '0;
            start      <= 1'b0;
            ready      <= 1'b0;
            pll_errors <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                s_issue: begin
                    if (!busy) begin
                        req   <= write_req(entry);
                        index <= index + 5'd1;
                        start <= 1'b1;
                        state <= s_wait_done;
                    end
                end
                s_wait_done: begin
                    if (done) begin
                        start <= 1'b1;
                        if (!rsp.ack_error) begin
                            if (index == 5'(INIT_LEN)) begin
                                req   <= PLL_READ;
                                state <= s_check_pll;
                            end else begin
                                req   <= write_req(entry);
                                index <= index + 5'd1;
                            end
                        end
                    end
                end
                s_check_pll: begin
                    if (done) begin
                        if (rsp.ack_error) begin
                            start <= 1'b1;
                        end else if (rsp.data[PLL_LOCK_BIT]) begin
                            ready <= 1'b1;
                            state <= s_idle;
                        end else begin
                            // no lock, run the whole table again
                            pll_errors <= pll_errors + 8'd1;
                            index      <= '0;
                            state      <= s_issue;
                        end
                    end
                end
                s_idle: begin
                    if (!int_sync) begin
                        ready <= 1'b0;
                        index <= '0;
                        state <= s_issue;
                    end
                end
                default: state <= s_issue;
            endcase
        end
    end

    // start only goes out once the master has finished the last transaction
    a_start_not_busy: assert property (@(posedge clk) disable iff (!reset)
        start |-> !busy);

    a_ready_idle: assert property (@(posedge clk) disable iff (!reset)
        ready |-> (state == s_idle));

endmodule

//--- i2c_master/i2c_master.sv
`timescale 1ns/1ns

module i2c_master
    import hdmi_tx_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  i2c_req_t req,
    input  logic     start,
    output logic     busy,
    output logic     done,
    output i2c_rsp_t rsp,
    inout  wire      sda,
    inout  wire      scl
);

    // symbol being sent, each one is four quarter-bit phases long
    typedef enum logic [1:0] {
        m_idle,
        m_start,
        m_byte,
        m_stop
    } m_state_e;

    // quarter lengths alternate so that each scl half lasts exactly CLK_DIV cycles
    localparam int Q_EVEN = CLK_DIV / 2;
    localparam int Q_ODD = CLK_DIV - CLK_DIV / 2;
    localparam int DIV_W = $clog2(Q_ODD + 1);

    m_state_e         state;
    i2c_req_t         req_q;
    logic [DIV_W-1:0] div_cnt;
    logic [DIV_W-1:0] quarter_last;
    logic [1:0]       phase;
    logic [3:0]       bit_cnt;
    logic [2:0]       step;
    logic [2:0]       next_step;
    logic [7:0]       shreg;
    logic [7:0]       rd_data;
    logic             ack_err;
    logic             tick;
    logic             rx_byte;
    logic             tx_bit;
    logic             sda_low;
    logic             scl_low;

    // write steps: start, addr, reg, value, stop
    // read steps: start, addr, reg, start, addr+1, data in, stop
    function automatic m_state_e symbol_of(logic [2:0] s, logic rd);
        if (s == 3'd0 || (rd && s == 3'd3)) begin
            symbol_of = m_start;
        end else if (s == (rd ? 3'd6 : 3'd4)) begin
            symbol_of = m_stop;
        end else begin
            symbol_of = m_byte;
        end
    endfunction

    function automatic logic [7:0] byte_of(logic [2:0] s, i2c_req_t r);
        case (s)
            3'd1:    byte_of = {r.chip_addr, 1'b0};
            3'd2:    byte_of = r.reg_addr;
            3'd3:    byte_of = r.value;
            3'd4:    byte_of = {r.chip_addr, 1'b1};
            default: byte_of = 8'hFF;
        endcase
    endfunction

    assign quarter_last = phase[0] ? DIV_W'(Q_ODD - 1) : DIV_W'(Q_EVEN - 1);
    assign tick = (state != m_idle) && (div_cnt == quarter_last);
    assign next_step = step + 3'd1;
    assign rx_byte = req_q.is_read && (step == 3'd5);
    // ack slot and the read data byte leave sda released, which NACKs the read
    assign tx_bit = (rx_byte || bit_cnt == 4'd8) ? 1'b1 : shreg[7];

    // scl is high in phases 1 and 2, sda changes only in phase 0 or under scl high
    always_comb begin
        sda_low = 1'b0;
        scl_low = 1'b0;
        case (state)
            m_start: begin
                scl_low = (phase == 2'd0) || (phase == 2'd3);
                sda_low = phase[1];
            end
            m_byte: begin
                scl_low = (phase == 2'd0) || (phase == 2'd3);
                sda_low = !tx_bit;
            end
            m_stop: begin
                scl_low = (phase == 2'd0);
                sda_low = !phase[1];
            end
            default: ;
        endcase
    end

    assign sda = sda_low ? 1'b0 : 1'bz;
    assign scl = scl_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= m_idle;
            busy    <= 1'b0;
            done    <= 1'b0;
            div_cnt <= '0;
            phase   <= '0;
            bit_cnt <= '0;
            step    <= '0;
        end else begin
            done <= 1'b0;
            if (done) begin
                busy <= 1'b0;
            end
            if (state == m_idle) begin
                if (start) begin
                    req_q   <= req;
                    ack_err <= 1'b0;
                    busy    <= 1'b1;
                    step    <= '0;
                    phase   <= '0;
                    div_cnt <= '0;
                    state   <= m_start;
                end
            end else if (!tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                phase   <= phase + 2'd1;
                // sample in the middle of the scl high time
                if (state == m_byte && phase == 2'd2) begin
                    if (bit_cnt == 4'd8) begin
                        if (!rx_byte && sda) begin
                            ack_err <= 1'b1;
                        end
                    end else if (rx_byte) begin
                        rd_data <= {rd_data[6:0], sda};
                    end
                end
                if (phase == 2'd3) begin
                    if (state == m_byte && bit_cnt != 4'd8) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        shreg   <= {shreg[6:0], 1'b0};
                    end else if (state == m_stop) begin
                        state <= m_idle;
                        done  <= 1'b1;
                        rsp   <= '{data: rd_data, ack_error: ack_err};
                    end else begin
                        step    <= next_step;
                        state   <= symbol_of(next_step, req_q.is_read);
                        shreg   <= byte_of(next_step, req_q);
                        bit_cnt <= '0;
                    end
                end
            end
        end
    end

    // a transaction is never lost between start and busy
    a_start_takes: assert property (@(posedge clk) disable iff (!reset)
        start |=> (busy || done));

endmodule

//--- logic/init_rom.sv
`timescale 1ns/1ns

module init_rom
    import hdmi_tx_pkg::*;
#(
    parameter bit ASPECT_16_9 = 1'b0
) (
    input  logic [4:0]  index,
    output init_entry_t entry
);

    // input aspect ratio flag lives in bit 1 of register 0x17
    localparam logic [7:0] ASPECT_BITS = ASPECT_16_9 ? 8'h02 : 8'h00;

    always_comb begin
        case (index)
            // power up all circuits, sync adjust off
            5'd0:  entry = '{reg_addr: 8'h41, value: 8'h10};
            // fixed values required by the chip
            5'd1:  entry = '{reg_addr: 8'h98, value: 8'h03};
            5'd2:  entry = '{reg_addr: 8'h9A, value: 8'hE0};
            5'd3:  entry = '{reg_addr: 8'h9C, value: 8'h30};
            5'd4:  entry = '{reg_addr: 8'h9D, value: 8'h01};
            5'd5:  entry = '{reg_addr: 8'hA2, value: 8'hA4};
            5'd6:  entry = '{reg_addr: 8'hA3, value: 8'hA4};
            5'd7:  entry = '{reg_addr: 8'hE0, value: 8'hD0};
            5'd8:  entry = '{reg_addr: 8'hF9, value: 8'h00};
            // 44.1 kHz audio, 24 bit RGB 4:4:4 with separate syncs
            5'd9:  entry = '{reg_addr: 8'h15, value: 8'h00};
            // 4:4:4 out, 8 bit colour depth
            5'd10: entry = '{reg_addr: 8'h16, value: 8'h30};
            // sync polarity pass through, DE generator off
            5'd11: entry = '{reg_addr: 8'h17, value: 8'h00 | ASPECT_BITS};
            // colour space converter off
            5'd12: entry = '{reg_addr: 8'h18, value: 8'h46};
            // HDMI mode, no HDCP
            5'd13: entry = '{reg_addr: 8'hAF, value: 8'h06};
            // no clock delay, external HDCP EEPROM
            5'd14: entry = '{reg_addr: 8'hBA, value: 8'h60};
            // automatic CTS, I2S audio, 128 fs MCLK
            5'd15: entry = '{reg_addr: 8'h0A, value: 8'h00};
            // audio clock regeneration N = 0x01880
            5'd16: entry = '{reg_addr: 8'h01, value: 8'h00};
            5'd17: entry = '{reg_addr: 8'h02, value: 8'h18};
            5'd18: entry = '{reg_addr: 8'h03, value: 8'h80};
            // no SPDIF, MCLK generated internally
            5'd19: entry = '{reg_addr: 8'h0B, value: 8'h0E};
            // I2S0 only, right justified
            5'd20: entry = '{reg_addr: 8'h0C, value: 8'h05};
            // 16 bit I2S samples
            5'd21: entry = '{reg_addr: 8'h0D, value: 8'h10};
            // enable HPD and monitor sense interrupts
            5'd22: entry = '{reg_addr: 8'h94, value: 8'hC0};
            // write ones to clear any pending interrupt
            5'd23: entry = '{reg_addr: 8'h96, value: 8'hC0};
            // past the end of the table, the sequencer never issues these
            default: entry = '{reg_addr: 8'h41, value: 8'h10};
        endcase
    end

endmodule

//--- common/hdmi_tx_pkg.sv
package hdmi_tx_pkg;

    // 7-bit bus address of the transmitter, 0x72/0x73 on the wire
    localparam logic [6:0] CHIP_ADDR = 7'h39;

    // PLL status register and the position of its lock flag
    localparam logic [7:0] REG_PLL_STATUS = 8'h9E;
    localparam int PLL_LOCK_BIT = 4;

    // number of register writes in the power-up table
    localparam int INIT_LEN = 24;

    // one row of the power-up table
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] value;
    } init_entry_t;

    // request to the bus master, held stable in the start cycle
    typedef struct packed {
        // 7-bit target address, the r/w bit is added by the master
        logic [6:0] chip_addr;
        logic [7:0] reg_addr;
        // ignored for reads
        logic [7:0] value;
        logic       is_read;
    } i2c_req_t;

    // response from the bus master, valid only with done
    typedef struct packed {
        // byte returned by a read
        logic [7:0] data;
        // some byte of the transaction went unacknowledged
        logic       ack_error;
    } i2c_rsp_t;

    // sequencer states
    // s_issue     first write of a pass, start goes out next cycle
    // s_wait_done a table write is on the bus
    // s_check_pll the PLL status read is on the bus
    // s_idle      configured, watching the interrupt line
    typedef enum logic [1:0] {
        s_issue,
        s_wait_done,
        s_check_pll,
        s_idle
    } seq_state_e;

endpackage
